/* sources.f */
+incdir+logic
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module cpu_tb -o Vcpu_tb
if [ $? -ne 0 ]; then
	echo "compile step failed"
	exit 1
fi

./obj_dir/Vcpu_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	exit 1
fi
exit 0

/* dv/cpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module cpu_tb;

	localparam int RESET_CYC = 5;
	localparam int RUN_CYC = 72;
	localparam int NUM_TESTS = 6;
	localparam int MAX_CYCLES = NUM_TESTS * (RESET_CYC + RUN_CYC + 2) + 100;
	localparam logic [31:0] NOP = 32'h0000_0013;

	logic clk;
	logic reset;
	logic [31:0] pc_addr, ldst_addr, ldst_wrdata, i_pc_rddata, i_ldst_rddata;
	logic pc_rd, ldst_rd, ldst_wr;
	logic [31:0] regs_obs [0:`NUM_REGS-1];

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	logic [31:0] prog [$];
	logic [31:0] model [0:31];
	logic pend_pc_rd, pend_ld;
	logic [31:0] pend_pc_addr, pend_ld_addr, wr_addr, wr_data;
	int wr_count, errors, tests_run, cycles;

	cpu_top DUT (
		.clk(clk), .reset(reset),
		.o_pc_addr(pc_addr), .o_pc_rd(pc_rd), .i_pc_rddata(i_pc_rddata),
		.o_ldst_addr(ldst_addr), .o_ldst_rd(ldst_rd), .o_ldst_wr(ldst_wr),
		.i_ldst_rddata(i_ldst_rddata), .o_ldst_wrdata(ldst_wrdata),
		.o_tb_regs(regs_obs)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("run stopped: cycle limit of %0d reached", MAX_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// instruction and data memories with registered read
	always @(negedge clk) begin
		i_pc_rddata = pend_pc_rd ? imem[pend_pc_addr[9:2]] : 32'h0;
		i_ldst_rddata = pend_ld ? dmem[pend_ld_addr[9:2]] : 32'h0;
		pend_pc_rd = pc_rd;
		pend_pc_addr = pc_addr;
		pend_ld = ldst_rd;
		pend_ld_addr = ldst_addr;
		if (ldst_wr) begin
			dmem[ldst_addr[9:2]] = ldst_wrdata;
			wr_count++;
			wr_addr = ldst_addr;
			wr_data = ldst_wrdata;
		end
	end

	function automatic logic [31:0] op_word(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] imm_word(int imm, int rs1, int f3, int rd, int opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
	endfunction

	function automatic logic [31:0] store_word(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] lui_word(logic [31:0] v, int rd);
		return {v[31:12], rd[4:0], 7'b0110111};
	endfunction

	function automatic logic [31:0] jal_word(int off, int rd);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	// lui plus addi with the upper part rounded for the signed low part
	task automatic load_const(int rd, logic [31:0] v);
		logic [31:0] lo;
		lo = {{20{v[11]}}, v[11:0]};
		prog.push_back(lui_word(v - lo, rd));
		prog.push_back(imm_word(int'(v[11:0]), rd, 0, rd, 7'h13));
		model[rd] = v;
	endtask

	task automatic start_test();
		prog.delete();
		for (int i = 0; i < 32; i++) begin
			model[i] = 32'h0;
		end
	endtask

	task automatic run_prog();
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		for (int i = 0; i < 256; i++) begin
			imem[i] = (i < prog.size()) ? prog[i] : NOP;
			dmem[i] = 32'hd00d_0000 ^ (i * 4);
		end
		wr_count = 0;
		repeat (RESET_CYC - 1) @(negedge clk);
		reset = 1'b0;
		repeat (RUN_CYC) @(negedge clk);
	endtask

	task automatic check_regs(string name, int err_before);
		for (int i = 0; i < 32; i++) begin
			if (regs_obs[i] !== model[i]) begin
				$display("MISMATCH %0t: %s x%0d got %h expected %h",
					$time, name, i, regs_obs[i], model[i]);
				errors++;
			end
		end
		tests_run++;
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic reg_reg_ops();
		logic [31:0] a, b;
		int e;
		e = errors;
		start_test();
		a = $urandom();
		b = $urandom();
		load_const(1, a);
		load_const(2, b);
		prog.push_back(op_word(0, 2, 1, 0, 3));
		prog.push_back(op_word(32, 2, 1, 0, 4));
		prog.push_back(op_word(0, 2, 1, 4, 5));
		prog.push_back(op_word(0, 2, 1, 6, 6));
		prog.push_back(op_word(0, 2, 1, 7, 7));
		prog.push_back(op_word(0, 2, 1, 1, 8));
		prog.push_back(op_word(0, 2, 1, 5, 9));
		prog.push_back(op_word(32, 2, 1, 5, 10));
		prog.push_back(op_word(0, 2, 1, 2, 11));
		prog.push_back(op_word(0, 2, 1, 3, 12));
		model[3] = a + b;
		model[4] = a - b;
		model[5] = a ^ b;
		model[6] = a | b;
		model[7] = a & b;
		model[8] = a << b[4:0];
		model[9] = a >> b[4:0];
		model[10] = $signed(a) >>> b[4:0];
		model[11] = {31'b0, $signed(a) < $signed(b)};
		model[12] = {31'b0, a < b};
		run_prog();
		check_regs("reg_reg", e);
	endtask

	task automatic reg_imm_ops();
		logic [31:0] a;
		int e;
		e = errors;
		start_test();
		a = $urandom() | 32'h8000_0000;
		load_const(1, a);
		prog.push_back(imm_word(100, 1, 0, 3, 7'h13));
		prog.push_back(imm_word(-200, 1, 0, 4, 7'h13));
		prog.push_back(imm_word(-1, 1, 4, 5, 7'h13));
		prog.push_back(imm_word(12'h0f0, 1, 6, 6, 7'h13));
		prog.push_back(imm_word(12'h7ff, 1, 7, 7, 7'h13));
		prog.push_back(imm_word(3, 1, 1, 8, 7'h13));
		prog.push_back(imm_word(7, 1, 5, 9, 7'h13));
		prog.push_back(imm_word(12'h407, 1, 5, 10, 7'h13));
		prog.push_back(imm_word(5, 1, 2, 11, 7'h13));
		prog.push_back(imm_word(-1, 1, 3, 12, 7'h13));
		model[3] = a + 32'd100;
		model[4] = a - 32'd200;
		model[5] = ~a;
		model[6] = a | 32'h0f0;
		model[7] = a & 32'h7ff;
		model[8] = a << 3;
		model[9] = a >> 7;
		model[10] = $signed(a) >>> 7;
		// a is negative so below 5 when signed
		model[11] = 32'd1;
		model[12] = {31'b0, a != 32'hffff_ffff};
		run_prog();
		check_regs("reg_imm", e);
	endtask

	task automatic forward_chain();
		logic [31:0] a, b;
		int e;
		e = errors;
		start_test();
		a = $urandom();
		b = $urandom();
		load_const(1, a);
		load_const(2, b);
		prog.push_back(op_word(0, 2, 1, 0, 3));
		prog.push_back(op_word(32, 1, 3, 0, 3));
		prog.push_back(op_word(0, 3, 3, 0, 3));
		prog.push_back(op_word(32, 2, 3, 0, 4));
		prog.push_back(op_word(0, 3, 4, 0, 4));
		model[3] = ((a + b) - a) * 2;
		model[4] = (model[3] - b) + model[3];
		run_prog();
		check_regs("forwarding", e);
	endtask

	task automatic x0_writes();
		logic [31:0] a;
		int e;
		e = errors;
		start_test();
		a = $urandom();
		load_const(1, a);
		prog.push_back(op_word(0, 1, 1, 0, 0));
		prog.push_back(lui_word(32'h1234_5000, 0));
		prog.push_back(imm_word(5, 0, 0, 0, 7'h13));
		prog.push_back(op_word(0, 1, 0, 0, 2));
		model[2] = a;
		run_prog();
		check_regs("x0", e);
	endtask

	task automatic store_load();
		logic [31:0] v;
		int e;
		e = errors;
		start_test();
		v = $urandom();
		prog.push_back(imm_word(12'h100, 0, 0, 1, 7'h13));
		load_const(2, v);
		prog.push_back(store_word(8, 2, 1));
		prog.push_back(NOP);
		prog.push_back(imm_word(8, 1, 2, 3, 7'h03));
		prog.push_back(NOP);
		prog.push_back(op_word(0, 3, 3, 0, 4));
		model[1] = 32'h100;
		model[3] = v;
		model[4] = v + v;
		run_prog();
		if (wr_count != 1) begin
			$display("MISMATCH %0t: store count %0d expected 1", $time, wr_count);
			errors++;
		end
		if (wr_addr !== 32'h108 || wr_data !== v) begin
			$display("MISMATCH %0t: store addr %h data %h expected 00000108 %h",
				$time, wr_addr, wr_data, v);
			errors++;
		end
		check_regs("memory", e);
	endtask

	task automatic jal_squash();
		int e;
		e = errors;
		start_test();
		prog.push_back(imm_word(7, 0, 0, 5, 7'h13));
		prog.push_back(imm_word(9, 0, 0, 6, 7'h13));
		// jal at pc 8 lands on pc 20
		prog.push_back(jal_word(12, 1));
		prog.push_back(imm_word(1, 0, 0, 5, 7'h13));
		prog.push_back(imm_word(2, 0, 0, 6, 7'h13));
		prog.push_back(imm_word(3, 0, 0, 7, 7'h13));
		model[1] = 32'd12;
		model[5] = 32'd7;
		model[6] = 32'd9;
		model[7] = 32'd3;
		run_prog();
		check_regs("jal", e);
	endtask

	initial begin
		void'($urandom(79));
		reset = 1'b1;
		i_pc_rddata = 32'h0;
		i_ldst_rddata = 32'h0;
		pend_pc_rd = 1'b0;
		pend_ld = 1'b0;
		pend_pc_addr = 32'h0;
		pend_ld_addr = 32'h0;
		errors = 0;
		tests_run = 0;
		cycles = 0;
		reg_reg_ops();
		reg_imm_ops();
		forward_chain();
		x0_writes();
		store_load();
		jal_squash();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* dv/cpu_chk.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module cpu_chk (
	input wire clk,
	input wire reset,
	input wire pc_rd,
	input wire [`XLEN-1:0] pc_addr,
	input wire ldst_rd,
	input wire ldst_wr,
	input wire [`XLEN-1:0] reg0
);

	// one data access per cycle
	a_one_strobe: assert property (@(posedge clk) !(ldst_rd && ldst_wr))
		else $error("load and store strobes high together");

	// flops are cleared after the first reset edge
	a_reset_quiet: assert property (@(posedge clk)
		(reset && $past(reset)) |-> (!pc_rd && !ldst_rd && !ldst_wr))
		else $error("strobe high during reset");

	a_x0_zero: assert property (@(posedge clk) disable iff (reset) reg0 == '0)
		else $error("x0 is not zero");

	a_pc_align: assert property (@(posedge clk) disable iff (reset) pc_addr[1:0] == 2'b00)
		else $error("fetch address not word aligned");

endmodule

bind cpu_top cpu_chk u_chk (
	.clk(clk),
	.reset(reset),
	.pc_rd(o_pc_rd),
	.pc_addr(o_pc_addr),
	.ldst_rd(o_ldst_rd),
	.ldst_wr(o_ldst_wr),
	.reg0(o_tb_regs[0])
);

`default_nettype wire

/* logic/cpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module cpu_top
	import rv_pkg::*;
(
	input wire clk,
	input wire reset,
	output logic [`XLEN-1:0] o_pc_addr,
	output logic o_pc_rd,
	input wire [`XLEN-1:0] i_pc_rddata,
	output logic [`XLEN-1:0] o_ldst_addr,
	output logic o_ldst_rd,
	output logic o_ldst_wr,
	input wire [`XLEN-1:0] i_ldst_rddata,
	output logic [`XLEN-1:0] o_ldst_wrdata,
	output logic [`XLEN-1:0] o_tb_regs [0:`NUM_REGS-1]
);

	// fetch to decode
	logic fetch_valid;
	logic [`XLEN-1:0] fetch_pc;

	// decode to execute
	logic dec_valid;
	logic [`XLEN-1:0] dec_pc;
	opcode_e dec_opcode;
	alu_op_e dec_alu_op;
	logic dec_use_imm;
	logic [`XLEN-1:0] dec_imm;
	logic [`REG_ADDR_W-1:0] dec_rs1;
	logic [`REG_ADDR_W-1:0] dec_rs2;
	logic [`REG_ADDR_W-1:0] dec_rd;

	// jal redirect
	logic redirect;
	logic [`XLEN-1:0] target;

	// register file reads
	logic [`REG_ADDR_W-1:0] rs1_idx;
	logic [`REG_ADDR_W-1:0] rs2_idx;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;

	// execute to result
	logic wb_valid;
	logic [`REG_ADDR_W-1:0] wb_rd;
	logic wb_is_load;
	logic [`XLEN-1:0] wb_result;

	fetch_unit u_fetch (
		.clk(clk),
		.reset(reset),
		.i_redirect(redirect),
		.i_target(target),
		.o_pc_addr(o_pc_addr),
		.o_pc_rd(o_pc_rd),
		.o_fetch_valid(fetch_valid),
		.o_fetch_pc(fetch_pc)
	);

	decode_stage u_decode (
		.clk(clk),
		.reset(reset),
		.i_fetch_valid(fetch_valid),
		.i_fetch_pc(fetch_pc),
		.i_instr(i_pc_rddata),
		.i_redirect(redirect),
		.o_valid(dec_valid),
		.o_pc(dec_pc),
		.o_opcode(dec_opcode),
		.o_alu_op(dec_alu_op),
		.o_use_imm(dec_use_imm),
		.o_imm(dec_imm),
		.o_rs1(dec_rs1),
		.o_rs2(dec_rs2),
		.o_rd(dec_rd)
	);

	execute_stage u_execute (
		.clk(clk),
		.reset(reset),
		.i_valid(dec_valid),
		.i_pc(dec_pc),
		.i_opcode(dec_opcode),
		.i_alu_op(dec_alu_op),
		.i_use_imm(dec_use_imm),
		.i_imm(dec_imm),
		.i_rs1(dec_rs1),
		.i_rs2(dec_rs2),
		.i_rd(dec_rd),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.o_rs1_idx(rs1_idx),
		.o_rs2_idx(rs2_idx),
		.o_redirect(redirect),
		.o_target(target),
		.o_ldst_addr(o_ldst_addr),
		.o_ldst_rd(o_ldst_rd),
		.o_ldst_wr(o_ldst_wr),
		.o_ldst_wrdata(o_ldst_wrdata),
		.o_wb_valid(wb_valid),
		.o_wb_rd(wb_rd),
		.o_wb_is_load(wb_is_load),
		.o_wb_result(wb_result)
	);

	result_stage u_result (
		.clk(clk),
		.reset(reset),
		.i_wb_valid(wb_valid),
		.i_wb_rd(wb_rd),
		.i_wb_is_load(wb_is_load),
		.i_wb_result(wb_result),
		.i_ldst_rddata(i_ldst_rddata),
		.i_rs1_idx(rs1_idx),
		.i_rs2_idx(rs2_idx),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.o_regs(o_tb_regs)
	);

endmodule

`default_nettype wire

/* logic/result_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module result_stage (
	input wire clk,
	input wire reset,
	input wire i_wb_valid,
	input wire [`REG_ADDR_W-1:0] i_wb_rd,
	input wire i_wb_is_load,
	input wire [`XLEN-1:0] i_wb_result,
	input wire [`XLEN-1:0] i_ldst_rddata,
	input wire [`REG_ADDR_W-1:0] i_rs1_idx,
	input wire [`REG_ADDR_W-1:0] i_rs2_idx,
	output logic [`XLEN-1:0] o_rs1_data,
	output logic [`XLEN-1:0] o_rs2_data,
	output logic [`XLEN-1:0] o_regs [0:`NUM_REGS-1]
);

	logic [`XLEN-1:0] regs [0:`NUM_REGS-1];
	logic [`XLEN-1:0] wr_data;

	// load word comes straight off the data port
	assign wr_data = i_wb_is_load ? i_ldst_rddata : i_wb_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_wb_valid && i_wb_rd != '0) begin
			regs[i_wb_rd] <= wr_data;
		end
	end

	// x0 reads as zero
	assign o_rs1_data = (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
	assign o_rs2_data = (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];

	assign o_regs = regs;

endmodule

`default_nettype wire

/* logic/execute_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module execute_stage
	import rv_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire i_valid,
	input wire [`XLEN-1:0] i_pc,
	input wire opcode_e i_opcode,
	input wire alu_op_e i_alu_op,
	input wire i_use_imm,
	input wire [`XLEN-1:0] i_imm,
	input wire [`REG_ADDR_W-1:0] i_rs1,
	input wire [`REG_ADDR_W-1:0] i_rs2,
	input wire [`REG_ADDR_W-1:0] i_rd,
	input wire [`XLEN-1:0] i_rs1_data,
	input wire [`XLEN-1:0] i_rs2_data,
	output logic [`REG_ADDR_W-1:0] o_rs1_idx,
	output logic [`REG_ADDR_W-1:0] o_rs2_idx,
	output logic o_redirect,
	output logic [`XLEN-1:0] o_target,
	output logic [`XLEN-1:0] o_ldst_addr,
	output logic o_ldst_rd,
	output logic o_ldst_wr,
	output logic [`XLEN-1:0] o_ldst_wrdata,
	output logic o_wb_valid,
	output logic [`REG_ADDR_W-1:0] o_wb_rd,
	output logic o_wb_is_load,
	output logic [`XLEN-1:0] o_wb_result
);

	localparam int SHAMT_W = $clog2(`XLEN);

	logic fwd_ok;
	logic [`XLEN-1:0] src_a;
	logic [`XLEN-1:0] src_b;
	logic [`XLEN-1:0] op_b;
	logic [SHAMT_W-1:0] shamt;
	logic [`XLEN-1:0] alu_out;
	logic [`XLEN-1:0] link;
	logic writes_rd;

	assign o_rs1_idx = i_rs1;
	assign o_rs2_idx = i_rs2;

	// previous result is not yet in the register file
	// load data arrives too late to forward
	assign fwd_ok = o_wb_valid && !o_wb_is_load && (o_wb_rd != '0);
	assign src_a = (fwd_ok && o_wb_rd == i_rs1) ? o_wb_result : i_rs1_data;
	assign src_b = (fwd_ok && o_wb_rd == i_rs2) ? o_wb_result : i_rs2_data;

	assign op_b = i_use_imm ? i_imm : src_b;
	assign shamt = op_b[SHAMT_W-1:0];

	always_comb begin
		case (i_alu_op)
			ALU_ADD: alu_out = src_a + op_b;
			ALU_SUB: alu_out = src_a - op_b;
			ALU_XOR: alu_out = src_a ^ op_b;
			ALU_OR: alu_out = src_a | op_b;
			ALU_AND: alu_out = src_a & op_b;
			ALU_SLL: alu_out = src_a << shamt;
			ALU_SRL: alu_out = src_a >> shamt;
			ALU_SRA: alu_out = $signed(src_a) >>> shamt;
			ALU_SLT: alu_out = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(op_b)};
			ALU_SLTU: alu_out = {{(`XLEN-1){1'b0}}, src_a < op_b};
			ALU_PASS_B: alu_out = op_b;
			default: alu_out = src_a + op_b;
		endcase
	end

	// jal link and target
	assign link = i_pc + `INSTR_BYTES;
	assign o_target = i_pc + i_imm;
	assign o_redirect = i_valid && (i_opcode == JAL);

	// load and store address comes from the adder path
	assign o_ldst_addr = alu_out;
	assign o_ldst_wrdata = src_b;
	assign o_ldst_rd = i_valid && (i_opcode == LOAD);
	assign o_ldst_wr = i_valid && (i_opcode == STORE);

	always_comb begin
		case (i_opcode)
			OP, OP_IMM, LUI, JAL, LOAD: writes_rd = i_valid;
			default: writes_rd = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wb_valid <= 1'b0;
		end else begin
			o_wb_valid <= writes_rd;
		end
	end

	// write-back record
	always_ff @(posedge clk) begin
		o_wb_rd <= i_rd;
		o_wb_is_load <= (i_opcode == LOAD);
		o_wb_result <= (i_opcode == JAL) ? link : alu_out;
	end

endmodule

`default_nettype wire

/* logic/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module decode_stage
	import rv_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire i_fetch_valid,
	input wire [`XLEN-1:0] i_fetch_pc,
	input wire [`XLEN-1:0] i_instr,
	input wire i_redirect,
	output logic o_valid,
	output logic [`XLEN-1:0] o_pc,
	output opcode_e o_opcode,
	output alu_op_e o_alu_op,
	output logic o_use_imm,
	output logic [`XLEN-1:0] o_imm,
	output logic [`REG_ADDR_W-1:0] o_rs1,
	output logic [`REG_ADDR_W-1:0] o_rs2,
	output logic [`REG_ADDR_W-1:0] o_rd
);

	logic [6:0] opc_bits;
	logic [2:0] funct3;
	logic alt_bit;
	logic known;
	logic use_imm;
	alu_op_e arith_op;
	alu_op_e alu_op;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;

	assign opc_bits = i_instr[6:0];
	assign funct3 = i_instr[14:12];
	// funct7 bit 5 selects sub and sra
	assign alt_bit = i_instr[30];

	// immediate formats
	assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
	assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
	assign imm_u = {i_instr[31:12], 12'b0};
	assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

	// shared funct3 map for OP and OP_IMM
	always_comb begin
		case (funct3)
			3'b000: arith_op = (opc_bits == OP && alt_bit) ? ALU_SUB : ALU_ADD;
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = alt_bit ? ALU_SRA : ALU_SRL;
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	end

	always_comb begin
		known = 1'b1;
		use_imm = 1'b1;
		imm = imm_i;
		alu_op = ALU_ADD;
		case (opc_bits)
			OP: begin
				use_imm = 1'b0;
				alu_op = arith_op;
			end
			OP_IMM: alu_op = arith_op;
			LUI: begin
				imm = imm_u;
				alu_op = ALU_PASS_B;
			end
			JAL: imm = imm_j;
			LOAD: imm = imm_i;
			STORE: imm = imm_s;
			default: known = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_valid <= 1'b0;
		end else begin
			// younger slot behind a jal is dropped
			o_valid <= i_fetch_valid && known && !i_redirect;
		end
	end

	always_ff @(posedge clk) begin
		o_pc <= i_fetch_pc;
		o_opcode <= opcode_e'(opc_bits);
		o_alu_op <= alu_op;
		o_use_imm <= use_imm;
		o_imm <= imm;
		o_rs1 <= i_instr[19:15];
		o_rs2 <= i_instr[24:20];
		o_rd <= i_instr[11:7];
	end

endmodule

`default_nettype wire

/* logic/fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_params.svh"

module fetch_unit (
	input wire clk,
	input wire reset,
	input wire i_redirect,
	input wire [`XLEN-1:0] i_target,
	output logic [`XLEN-1:0] o_pc_addr,
	output logic o_pc_rd,
	output logic o_fetch_valid,
	output logic [`XLEN-1:0] o_fetch_pc
);

	logic [`XLEN-1:0] pc;
	logic pc_rd;

	assign o_pc_addr = pc;
	assign o_pc_rd = pc_rd;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
			pc_rd <= 1'b0;
			o_fetch_valid <= 1'b0;
		end else begin
			pc_rd <= 1'b1;
			// jal target wins over the sequential step
			if (i_redirect) begin
				pc <= i_target;
			end else if (pc_rd) begin
				pc <= pc + `INSTR_BYTES;
			end
			// word in flight during a redirect is a squashed slot
			o_fetch_valid <= pc_rd && !i_redirect;
		end
	end

	// pc of the word the memory returns next cycle
	always_ff @(posedge clk) begin
		o_fetch_pc <= pc;
	end

endmodule

`default_nettype wire

/* logic/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	// major opcodes handled by this core
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		JAL    = 7'b1101111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	// operations of the execute ALU
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_XOR    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_AND    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_SLT    = 4'd8,
		ALU_SLTU   = 4'd9,
		// operand b straight through, used by lui
		ALU_PASS_B = 4'd10
	} alu_op_e;

endpackage

`default_nettype wire

/* logic/rv_params.svh */
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data path and address width
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// pc step between sequential instructions
`define INSTR_BYTES 4

// address of the first fetch out of reset
`define RESET_PC 32'h0000_0000

`endif
